// File: dv/ddr2pe_config_tb.sv
`timescale 1ns/1ps
`include "cfg_settings.svh"

module ddr2pe_config_tb
    import cfg_pkg::*;
();

    localparam int NUM_INS    = 300;
    localparam int WAIT_LIMIT = 100;

    logic                clk;
    logic                rst;
    logic [`MODE_W-1:0]  layer_type;
    logic                ins_valid;
    logic                ins_ready;
    logic [`INS_W-1:0]   ins;
    logic [3:0]          done_i;
    logic [3:0]          start_o;
    logic [3:0]          busy_o;
    logic [`MODE_W-1:0]  mode_o  [4];
    logic [`CNT_W-1:0]   count_o [4];
    logic [`PE_NUM-1:0]  mask_o  [4];

    // reference model state
    logic [3:0]          done_seen;
    logic [3:0]          exp_busy;
    logic [`MODE_W-1:0]  exp_mode  [4];
    logic [`CNT_W-1:0]   exp_count [4];
    logic [`PE_NUM-1:0]  exp_mask  [4];
    logic [`MODE_W-1:0]  nxt_mode;
    logic [`CNT_W-1:0]   nxt_count;
    logic [`PE_NUM-1:0]  nxt_mask  [4];
    int                  rise_cnt  [4];
    int                  fall_cnt  [4];
    string               buf_name  [4] = '{"i", "d", "p", "a"};

    ddr2pe_config_top dut (
        .clk        (clk),
        .rst        (rst),
        .layer_type (layer_type),
        .ins_valid  (ins_valid),
        .ins_ready  (ins_ready),
        .ins        (ins),
        .i_start (start_o[BUF_I]), .i_done (done_i[BUF_I]), .i_mode (mode_o[BUF_I]),
        .i_count (count_o[BUF_I]), .i_mask (mask_o[BUF_I]), .i_busy (busy_o[BUF_I]),
        .d_start (start_o[BUF_D]), .d_done (done_i[BUF_D]), .d_mode (mode_o[BUF_D]),
        .d_count (count_o[BUF_D]), .d_mask (mask_o[BUF_D]), .d_busy (busy_o[BUF_D]),
        .p_start (start_o[BUF_P]), .p_done (done_i[BUF_P]), .p_mode (mode_o[BUF_P]),
        .p_count (count_o[BUF_P]), .p_mask (mask_o[BUF_P]), .p_busy (busy_o[BUF_P]),
        .a_start (start_o[BUF_A]), .a_done (done_i[BUF_A]), .a_mode (mode_o[BUF_A]),
        .a_count (count_o[BUF_A]), .a_mask (mask_o[BUF_A]), .a_busy (busy_o[BUF_A])
    );

    always #50 clk = ~clk;

    // ====================
    // checks and model
    // ====================
    task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string msg);
        if (got !== exp) begin
            $display("error: %0t ns: %s (got %0h, expected %0h)", $time, msg, got, exp);
            $display("Simulation finished: FAIL");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic give_up(input string what);
        $display("%s", what);
        $display("Simulation finished: FAIL");
        $fatal(1, "wait expired");
    endtask

    // bit order a, p, d, i
    function automatic logic [3:0] selected_buffers(logic [3:0] opc, logic [`MODE_W-1:0] lt);
        logic pool;
        logic [3:0] s;
        pool = (lt[2:1] == `POOL_KIND);
        case (opc)
            RD_OP_D:  s = 4'b0010;
            RD_OP_G:  s = pool ? 4'b0110 : 4'b0010;
            RD_OP_DW: s = pool ? 4'b1001 : 4'b0101;
            default:  s = pool ? 4'b1000 : 4'b0000;
        endcase
        return s;
    endfunction

    function automatic logic [`PE_NUM-1:0] pe_mask_for(int id, logic [`MODE_W-1:0] lt);
        logic [`PE_NUM-1:0] m;
        m = '0;
        if (lt[0]) begin
            if (id < `PE_NUM) m[id] = 1'b1;
        end else begin
            for (int k = 4 * id; k < 4 * id + 4; k++) begin
                if (k < `PE_NUM) m[k] = 1'b1;
            end
        end
        return m;
    endfunction

    function automatic logic [45:0] slot_state(int b);
        return {start_o[b], busy_o[b], mode_o[b], count_o[b], mask_o[b]};
    endfunction

    // one clock; launch is the set of buffers started at the coming edge
    task automatic step(input logic [3:0] launch);
        for (int b = 0; b < 4; b++) begin
            if (launch[b]) begin
                exp_busy[b]  = 1'b1;
                exp_mode[b]  = nxt_mode;
                exp_count[b] = nxt_count;
                exp_mask[b]  = nxt_mask[b];
            end else if (done_i[b] && !done_seen[b]) begin
                exp_busy[b] = 1'b0;
            end
            done_seen[b] = done_i[b];
        end
        @(negedge clk);
        for (int b = 0; b < 4; b++) begin
            check_eq(64'(slot_state(b)),
                     64'({launch[b], exp_busy[b], exp_mode[b], exp_count[b], exp_mask[b]}),
                     $sformatf("buffer %s start/busy/mode/count/mask", buf_name[b]));
        end
        // done responders
        for (int b = 0; b < 4; b++) begin
            if (launch[b]) begin
                done_i[b]   = 1'b0;
                fall_cnt[b] = 0;
                rise_cnt[b] = 1 + int'($urandom % 20);
            end else if (rise_cnt[b] > 0) begin
                rise_cnt[b]--;
                if (rise_cnt[b] == 0) begin
                    done_i[b]   = 1'b1;
                    fall_cnt[b] = 1 + int'($urandom % 4);
                end
            end else if (fall_cnt[b] > 0) begin
                fall_cnt[b]--;
                if (fall_cnt[b] == 0) done_i[b] = 1'b0;
            end
        end
    endtask

    // ====================
    // one instruction
    // ====================
    task automatic run_one(input int n);
        logic [3:0]         opc;
        logic [`MODE_W-1:0] lt;
        logic [5:0]         id;
        logic [`CNT_W-1:0]  size;
        logic [3:0]         sel;
        int                 waited;
        int                 idle_low;
        case ($urandom % 6)
            0:       opc = RD_OP_D;
            1:       opc = RD_OP_G;
            2:       opc = RD_OP_DW;
            3:       opc = WR_OP;
            default: opc = 4'($urandom % 16);
        endcase
        id   = 6'($urandom % 16);
        size = 8'($urandom);
        lt   = 4'($urandom);
        repeat ($urandom % 4) step(4'b0000);
        ins = {$urandom, $urandom};
        ins[`OPC_LSB +: 4]  = opc;
        ins[`BID_LSB +: 6]  = id;
        ins[`SIZE_LSB +: 8] = size;
        layer_type = lt;
        ins_valid  = 1'b1;
        sel        = selected_buffers(opc, lt);
        nxt_mode   = lt;
        nxt_count  = size;
        for (int b = 0; b < 4; b++) begin
            nxt_mask[b] = (b == int'(BUF_D)) ? '1 : pe_mask_for(int'(id), lt);
        end
        step(sel);
        check_eq(64'(ins_ready), 64'(0), "ins_ready low after accept");
        waited   = 0;
        idle_low = 0;
        while (!ins_ready) begin
            if (exp_busy == 4'b0000) idle_low++;
            check_eq(64'(idle_low <= 2), 64'(1), "ins_ready late after last busy cleared");
            if (waited > WAIT_LIMIT) begin
                give_up($sformatf("ins_ready never came back after instruction %0d", n));
            end
            // held-off pulses must not start anything
            ins_valid  = 1'($urandom % 2);
            ins        = {$urandom, $urandom};
            layer_type = 4'($urandom);
            step(4'b0000);
            waited++;
        end
        ins_valid = 1'b0;
        check_eq(64'(exp_busy), 64'(0), "ins_ready high while a buffer is busy");
        if (sel == 4'b0000) begin
            check_eq(64'(waited), 64'(2), "ins_ready return after empty instruction");
        end
    endtask

    initial begin
        void'($urandom(32'h3c3cd155));
        clk        = 1'b0;
        rst        = 1'b1;
        ins_valid  = 1'b0;
        ins        = '0;
        layer_type = '0;
        done_i     = '0;
        done_seen  = '0;
        exp_busy   = '0;
        nxt_mode   = '0;
        nxt_count  = '0;
        for (int b = 0; b < 4; b++) begin
            exp_mode[b]  = '0;
            exp_count[b] = '0;
            exp_mask[b]  = '0;
            nxt_mask[b]  = '0;
            rise_cnt[b]  = 0;
            fall_cnt[b]  = 0;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_eq(64'(ins_ready), 64'(1), "ins_ready after reset");
        for (int b = 0; b < 4; b++) begin
            check_eq(64'(slot_state(b)), 64'(0),
                     $sformatf("buffer %s outputs after reset", buf_name[b]));
        end
        for (int n = 0; n < NUM_INS; n++) begin
            run_one(n);
        end
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// File: logic/buf_launcher.sv
`timescale 1ns/1ps
`include "cfg_settings.svh"

module buf_launcher
    import cfg_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                accept,
    slot_cmd_if.dst             cmd,
    input  logic                done,
    output logic                start,
    output logic [`MODE_W-1:0]  mode,
    output logic [`CNT_W-1:0]   count,
    output logic [`PE_NUM-1:0]  mask,
    output logic                busy
);

    logic launch;
    logic done_q;
    logic done_rise;

    assign launch    = accept & cmd.sel;
    assign done_rise = done & ~done_q;

    // ====================
    // config + start
    // ====================
    always_ff @(posedge clk) begin
        if (rst) begin
            start <= 1'b0;
            mode  <= '0;
            count <= '0;
            mask  <= '0;
        end else begin
            start <= launch;
            // unselected slots hold the last config
            if (launch) begin
                mode  <= cmd.mode;
                count <= cmd.count;
                mask  <= cmd.mask;
            end
        end
    end

    // ====================
    // busy tracking
    // ====================
    always_ff @(posedge clk) begin
        if (rst) begin
            done_q <= 1'b0;
        end else begin
            done_q <= done;
        end
    end

    // set wins; a new launch only happens with every slot idle
    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
        end else if (launch) begin
            busy <= 1'b1;
        end else if (done_rise) begin
            busy <= 1'b0;
        end
    end

endmodule

// File: logic/cfg_pkg.sv
package cfg_pkg;

    // load instruction opcodes
    // anything else counts as a non-read opcode
    typedef enum logic [3:0] {
        RD_OP_D  = 4'd0,
        RD_OP_G  = 4'd1,
        RD_OP_DW = 4'd2,
        WR_OP    = 4'd8
    } opcode_e;

    // buffer classes, also the slot order of the launcher array
    typedef enum logic [1:0] {
        BUF_I = 2'd0,
        BUF_D = 2'd1,
        BUF_P = 2'd2,
        BUF_A = 2'd3
    } buf_idx_e;

    // instruction issue tracking
    typedef enum logic [1:0] {
        TRK_IDLE = 2'd0,
        TRK_CONF = 2'd1,
        TRK_WORK = 2'd2
    } trk_state_e;

endpackage

// File: logic/cfg_settings.svh
`ifndef CFG_SETTINGS_SVH
`define CFG_SETTINGS_SVH

// ====================
// array geometry
// ====================
`define PE_NUM      32
`define BUF_NUM     4

// ====================
// instruction layout
// ====================
`define INS_W       64
`define OPC_LSB     58
`define BID_LSB     52
`define BID_W       6
`define SIZE_LSB    32

// buffer configuration widths
`define MODE_W      4
`define CNT_W       8

// layer_type[2:1] value of a pooling layer
`define POOL_KIND   2

`endif

// File: logic/ddr2pe_config_top.sv
`timescale 1ns/1ps
`include "cfg_settings.svh"

module ddr2pe_config_top
    import cfg_pkg::*;
(
    input  logic                clk,
    input  logic                rst,

    input  logic [`MODE_W-1:0]  layer_type,
    input  logic                ins_valid,
    output logic                ins_ready,
    input  logic [`INS_W-1:0]   ins,

    output logic                i_start,
    input  logic                i_done,
    output logic [`MODE_W-1:0]  i_mode,
    output logic [`CNT_W-1:0]   i_count,
    output logic [`PE_NUM-1:0]  i_mask,
    output logic                i_busy,

    output logic                d_start,
    input  logic                d_done,
    output logic [`MODE_W-1:0]  d_mode,
    output logic [`CNT_W-1:0]   d_count,
    output logic [`PE_NUM-1:0]  d_mask,
    output logic                d_busy,

    output logic                p_start,
    input  logic                p_done,
    output logic [`MODE_W-1:0]  p_mode,
    output logic [`CNT_W-1:0]   p_count,
    output logic [`PE_NUM-1:0]  p_mask,
    output logic                p_busy,

    output logic                a_start,
    input  logic                a_done,
    output logic [`MODE_W-1:0]  a_mode,
    output logic [`CNT_W-1:0]   a_count,
    output logic [`PE_NUM-1:0]  a_mask,
    output logic                a_busy
);

    logic                accept;
    logic [`BUF_NUM-1:0] start_vec;
    logic [`BUF_NUM-1:0] done_vec;
    logic [`BUF_NUM-1:0] busy_vec;
    logic [`MODE_W-1:0]  mode_arr  [`BUF_NUM];
    logic [`CNT_W-1:0]   count_arr [`BUF_NUM];
    logic [`PE_NUM-1:0]  mask_arr  [`BUF_NUM];

    slot_cmd_if cmd [`BUF_NUM] ();

    ins_decoder u_decoder (
        .ins        (ins),
        .layer_type (layer_type),
        .ins_valid  (ins_valid),
        .ins_ready  (ins_ready),
        .accept     (accept),
        .cmd        (cmd)
    );

    // one launcher per buffer class, slot order from buf_idx_e
    for (genvar g = 0; g < `BUF_NUM; g++) begin : g_buf
        buf_launcher u_launcher (
            .clk    (clk),
            .rst    (rst),
            .accept (accept),
            .cmd    (cmd[g]),
            .done   (done_vec[g]),
            .start  (start_vec[g]),
            .mode   (mode_arr[g]),
            .count  (count_arr[g]),
            .mask   (mask_arr[g]),
            .busy   (busy_vec[g])
        );
    end

    issue_tracker u_tracker (
        .clk       (clk),
        .rst       (rst),
        .accept    (accept),
        .busy      (busy_vec),
        .ins_ready (ins_ready)
    );

    // ====================
    // port groups
    // ====================
    assign done_vec = {a_done, p_done, d_done, i_done};

    assign i_start = start_vec[BUF_I];
    assign i_mode  = mode_arr[BUF_I];
    assign i_count = count_arr[BUF_I];
    assign i_mask  = mask_arr[BUF_I];
    assign i_busy  = busy_vec[BUF_I];

    assign d_start = start_vec[BUF_D];
    assign d_mode  = mode_arr[BUF_D];
    assign d_count = count_arr[BUF_D];
    assign d_mask  = mask_arr[BUF_D];
    assign d_busy  = busy_vec[BUF_D];

    assign p_start = start_vec[BUF_P];
    assign p_mode  = mode_arr[BUF_P];
    assign p_count = count_arr[BUF_P];
    assign p_mask  = mask_arr[BUF_P];
    assign p_busy  = busy_vec[BUF_P];

    assign a_start = start_vec[BUF_A];
    assign a_mode  = mode_arr[BUF_A];
    assign a_count = count_arr[BUF_A];
    assign a_mask  = mask_arr[BUF_A];
    assign a_busy  = busy_vec[BUF_A];

endmodule

// File: logic/ins_decoder.sv
`timescale 1ns/1ps
`include "cfg_settings.svh"

module ins_decoder
    import cfg_pkg::*;
(
    input  logic [`INS_W-1:0]   ins,
    input  logic [`MODE_W-1:0]  layer_type,
    input  logic                ins_valid,
    input  logic                ins_ready,
    output logic                accept,
    slot_cmd_if.src             cmd [`BUF_NUM]
);

    opcode_e             opcode;
    logic [`BID_W-1:0]   buf_id;
    logic [`CNT_W-1:0]   size;
    logic                pool;
    logic [`PE_NUM-1:0]  one_hot;
    logic [`PE_NUM-1:0]  quad;
    logic [`PE_NUM-1:0]  pe_mask;
    logic [`BUF_NUM-1:0] sel;
    logic [`PE_NUM-1:0]  mask [`BUF_NUM];

    // ====================
    // instruction fields
    // ====================
    assign accept = ins_valid & ins_ready;

    assign opcode = opcode_e'(ins[`OPC_LSB +: $bits(opcode_e)]);
    assign buf_id = ins[`BID_LSB +: `BID_W];
    assign size   = ins[`SIZE_LSB +: `CNT_W];
    assign pool   = (layer_type[2:1] == `POOL_KIND);

    // ====================
    // PE mask
    // ====================
    // shifts past the top fall off, so large ids give zero bits
    assign one_hot = {{(`PE_NUM-1){1'b0}}, 1'b1} << buf_id;
    assign quad    = {{(`PE_NUM-4){1'b0}}, 4'hf} << {buf_id, 2'b00};
    assign pe_mask = layer_type[0] ? one_hot : quad;

    // ====================
    // buffer selection
    // ====================
    always_comb begin
        sel        = '0;
        sel[BUF_I] = (opcode == RD_OP_DW);
        sel[BUF_D] = (opcode == RD_OP_D) || (opcode == RD_OP_G);
        sel[BUF_P] = ((opcode == RD_OP_G) && pool) ||
                     ((opcode == RD_OP_DW) && !pool);
        sel[BUF_A] = pool && (opcode != RD_OP_D) && (opcode != RD_OP_G);
    end

    // data buffer always spans the whole array
    assign mask[BUF_I] = pe_mask;
    assign mask[BUF_D] = '1;
    assign mask[BUF_P] = pe_mask;
    assign mask[BUF_A] = pe_mask;

    // same mode and count for every slot
    for (genvar g = 0; g < `BUF_NUM; g++) begin : g_cmd
        assign cmd[g].sel   = sel[g];
        assign cmd[g].mode  = layer_type;
        assign cmd[g].count = size;
        assign cmd[g].mask  = mask[g];
    end

endmodule

// File: logic/issue_tracker.sv
`timescale 1ns/1ps
`include "cfg_settings.svh"

module issue_tracker
    import cfg_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                accept,
    input  logic [`BUF_NUM-1:0] busy,
    output logic                ins_ready
);

    trk_state_e state;
    trk_state_e state_nxt;

    always_comb begin
        state_nxt = state;
        case (state)
            TRK_IDLE: begin
                if (accept) begin
                    state_nxt = TRK_CONF;
                end
            end
            // one cycle for the launchers' busy bits to appear
            TRK_CONF: begin
                state_nxt = TRK_WORK;
            end
            TRK_WORK: begin
                if (busy == '0) begin
                    state_nxt = TRK_IDLE;
                end
            end
            default: begin
                state_nxt = TRK_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= TRK_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // next instruction only once the previous one has drained
    assign ins_ready = (state == TRK_IDLE);

endmodule

// File: logic/slot_cmd_if.sv
`timescale 1ns/1ps
`include "cfg_settings.svh"

// one buffer's decoded command, valid in the accept cycle only
interface slot_cmd_if;
    logic                sel;
    logic [`MODE_W-1:0]  mode;
    logic [`CNT_W-1:0]   count;
    logic [`PE_NUM-1:0]  mask;

    modport src (
        output sel,
        output mode,
        output count,
        output mask
    );

    modport dst (
        input sel,
        input mode,
        input count,
        input mask
    );
endinterface

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --top-module ddr2pe_config_tb -f src.f -Mdir obj_dir; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/Vddr2pe_config_tb 2>&1)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "Simulation finished: PASS"; then
    exit 0
fi

echo "pass message not found"
exit 1

// File: src.f
+incdir+logic
logic/cfg_pkg.sv
logic/slot_cmd_if.sv
logic/ins_decoder.sv
logic/buf_launcher.sv
logic/issue_tracker.sv
logic/ddr2pe_config_top.sv
dv/ddr2pe_config_tb.sv
